/* bench/execute_assert.sv */
// ############################
// protocol checks on execute_stage
// disabled while nRST is low
// ############################
`timescale 1ns/1ns

module execute_assert
  import ex_pkg::*;
(
  input logic    CLK,
  input logic    nRST,
  input issue_t  issue,
  input logic    stall_commit,
  input logic    flush,
  input commit_t commit,
  input logic    mispredict,
  input logic    mispredict_ff
);

  // decode holds off while the latch is frozen
  no_issue_in_stall: assert property (@(posedge CLK) disable iff (!nRST)
    issue.valid |-> !stall_commit)
    else $error("operation issued while stall_commit is high");

  flush_clears_lanes: assert property (@(posedge CLK) disable iff (!nRST)
    flush |=> !(commit.au_valid | commit.mu_valid | commit.br.valid))
    else $error("commit lane still valid after flush");

  mispredict_delay: assert property (@(posedge CLK) disable iff (!nRST)
    mispredict_ff == $past(mispredict))
    else $error("mispredict_ff does not follow mispredict");

endmodule

bind execute_stage execute_assert u_assert (
  .CLK           (CLK),
  .nRST          (nRST),
  .issue         (issue),
  .stall_commit  (stall_commit),
  .flush         (flush),
  .commit        (commit),
  .mispredict    (mispredict),
  .mispredict_ff (mispredict_ff)
);

/* bench/execute_tb.sv */
// ############################
// directed tests for execute_stage
// one op or one multiply burst at a time
// ############################
`timescale 1ns/1ns

module execute_tb
  import ex_pkg::*;
();

  localparam int LANE_AU = 0;
  localparam int LANE_MU = 1;
  localparam int LANE_BR = 2;

  logic    CLK = 1'b0;
  logic    nRST;
  issue_t  issue;
  logic    stall_commit;
  logic    flush;
  commit_t commit;
  logic    mispredict;
  word_t   brj_addr;
  logic    mispredict_ff;
  logic    busy_mu;

  execute_stage dut_i (.*);

  always #5 CLK = ~CLK;

  task automatic check(input string name, input word_t exp, input word_t act);
    if (exp !== act) begin
      $display("ERR %s expected %0h actual %0h", name, exp, act);
      $display("Test failures found");
      $fatal(1, "check %s failed", name);
    end
  endtask

  function automatic logic lane_valid(input int lane);
    case (lane)
      LANE_AU: return commit.au_valid;
      LANE_MU: return commit.mu_valid;
      default: return commit.br.valid;
    endcase
  endfunction

  // edges counts rising edges since the drive edge of the op
  task automatic wait_lane(input int lane, input int start, output int edges);
    edges = start;
    @(negedge CLK);
    while (!lane_valid(lane)) begin
      if (edges >= 20) begin
        $display("no valid result on commit lane %0d within 20 cycles", lane);
        $display("Test failures found");
        $fatal(1, "commit lane wait timed out");
      end
      @(negedge CLK);
      edges++;
    end
  endtask

  task automatic send(input issue_t op);
    @(posedge CLK);
    issue <= op;
  endtask

  task automatic idle();
    @(posedge CLK);
    issue <= '0;
  endtask

  function automatic issue_t base_op(input unit_e unit);
    issue_t op;
    op       = '0;
    op.valid = 1'b1;
    op.unit  = unit;
    op.rd    = reg_idx_t'($urandom);
    op.tag   = cb_tag_t'($urandom);
    return op;
  endfunction

  // corner values show up often
  function automatic word_t pick_word();
    case ($urandom_range(5, 0))
      0: return 32'h8000_0000;
      1: return 32'hffff_ffff;
      default: return $urandom;
    endcase
  endfunction

  function automatic word_t alu_model(input alu_op_e op, input word_t a, input word_t b);
    case (op)
      ALU_ADD: return a + b;
      ALU_SUB: return a - b;
      ALU_AND: return a & b;
      ALU_OR:  return a | b;
      ALU_XOR: return a ^ b;
      ALU_SLL: return a << b[4:0];
      ALU_SRL: return a >> b[4:0];
      ALU_SRA: return word_t'({{32{a[31]}}, a} >> b[4:0]);
      ALU_SLT: return (a[31] != b[31]) ? word_t'(a[31]) : word_t'(a < b);
      default: return word_t'(a < b);
    endcase
  endfunction

  // full 64-bit product of sign or zero extended operands
  function automatic word_t mul_model(input mul_op_e op, input word_t a, input word_t b);
    logic [63:0] ea;
    logic [63:0] eb;
    logic [63:0] prod;
    ea = {32'h0, a};
    eb = {32'h0, b};
    if (op == MUL_MULH || op == MUL_MULHSU)
      ea = {{32{a[31]}}, a};
    if (op == MUL_MULH)
      eb = {{32{b[31]}}, b};
    prod = ea * eb;
    return (op == MUL_MUL) ? prod[31:0] : prod[63:32];
  endfunction

  // signed compare by flipping the sign bit
  function automatic logic br_taken(input br_op_e op, input word_t a, input word_t b);
    case (op)
      BR_BEQ:  return a == b;
      BR_BNE:  return a != b;
      BR_BLT:  return (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);
      BR_BGE:  return (a ^ 32'h8000_0000) >= (b ^ 32'h8000_0000);
      BR_BLTU: return a < b;
      BR_BGEU: return a >= b;
      default: return 1'b1;
    endcase
  endfunction

  task automatic alu_ops();
    issue_t op;
    int     edges;
    for (int i = 0; i < 40; i++) begin
      op          = base_op(UNIT_ALU);
      op.alu_op   = alu_op_e'(i % 10);
      op.rs1_data = pick_word();
      op.rs2_data = (i % 3 == 0) ? op.rs1_data : pick_word();
      send(op);
      idle();
      wait_lane(LANE_AU, 1, edges);
      check("alu_ops latency", 32'd1, word_t'(edges));
      check("alu_ops wdata", alu_model(op.alu_op, op.rs1_data, op.rs2_data),
            commit.au_wdata);
      check("alu_ops rd", word_t'(op.rd), word_t'(commit.au_rd));
      check("alu_ops tag", word_t'(op.tag), word_t'(commit.au_tag));
    end
  endtask

  task automatic mul_bursts();
    issue_t ops [4];
    int     edges;
    for (int m = 0; m < 4; m++) begin
      for (int k = 0; k < 4; k++) begin
        ops[k]          = base_op(UNIT_MUL);
        ops[k].mul_op   = mul_op_e'(m);
        ops[k].rs1_data = pick_word();
        ops[k].rs2_data = pick_word();
      end
      for (int k = 0; k < 4; k++) begin
        send(ops[k]);
      end
      idle();
      wait_lane(LANE_MU, 4, edges);
      check("mul_bursts latency", 32'd5, word_t'(edges));
      // one result per cycle in issue order
      for (int k = 0; k < 4; k++) begin
        if (k > 0)
          @(negedge CLK);
        check("mul_bursts valid", 32'd1, word_t'(commit.mu_valid));
        check("mul_bursts wdata",
              mul_model(ops[k].mul_op, ops[k].rs1_data, ops[k].rs2_data),
              commit.mu_wdata);
        check("mul_bursts rd", word_t'(ops[k].rd), word_t'(commit.mu_rd));
        check("mul_bursts tag", word_t'(ops[k].tag), word_t'(commit.mu_tag));
      end
    end
  endtask

  task automatic branch_ops();
    issue_t op;
    word_t  rnd;
    logic   tk;
    logic   exp_mp;
    word_t  exp_res;
    word_t  exp_addr;
    int     edges;
    for (int b = 0; b < 8; b++) begin
      for (int p = 0; p < 2; p++) begin
        op            = base_op((b >= 6) ? UNIT_JUMP : UNIT_BRANCH);
        op.br_op      = br_op_e'(b);
        op.prediction = p[0];
        op.rs1_data   = pick_word();
        op.rs2_data   = ($urandom_range(1, 0) == 1) ? op.rs1_data : pick_word();
        op.pc         = $urandom & 32'hffff_fffc;
        rnd           = $urandom;
        op.imm        = {{19{rnd[12]}}, rnd[12:1], 1'b0};
        tk            = br_taken(op.br_op, op.rs1_data, op.rs2_data);
        exp_res       = tk ? op.pc + op.imm : op.pc + 32'd4;
        exp_mp        = (op.unit == UNIT_JUMP) || (tk != op.prediction);
        if (op.br_op == BR_JALR)
          exp_addr = (op.rs1_data + op.imm) & 32'hffff_fffe;
        else if (op.br_op == BR_JAL)
          exp_addr = op.pc + op.imm;
        else
          exp_addr = exp_res;
        send(op);
        // redirect is combinational in the issue cycle
        @(negedge CLK);
        check("branch_ops mispredict", word_t'(exp_mp), word_t'(mispredict));
        if (exp_mp)
          check("branch_ops brj_addr", exp_addr, brj_addr);
        idle();
        if (op.unit == UNIT_JUMP) begin
          wait_lane(LANE_AU, 1, edges);
          check("branch_ops link", op.pc + 32'd4, commit.au_wdata);
          check("branch_ops link rd", word_t'(op.rd), word_t'(commit.au_rd));
        end else begin
          wait_lane(LANE_BR, 1, edges);
          check("branch_ops taken", word_t'(tk), word_t'(commit.br.taken));
          check("branch_ops prediction", word_t'(op.prediction),
                word_t'(commit.br.prediction));
          check("branch_ops resolved", exp_res, commit.br.resolved_addr);
          check("branch_ops tag", word_t'(op.tag), word_t'(commit.br.tag));
        end
        check("branch_ops latency", 32'd1, word_t'(edges));
        check("branch_ops mispredict_ff", word_t'(exp_mp), word_t'(mispredict_ff));
      end
    end
  endtask

  task automatic stall_during_mul();
    issue_t  op;
    commit_t snap;
    int      n;
    int      edges;
    for (int r = 0; r < 4; r++) begin
      n           = $urandom_range(3, 1);
      op          = base_op(UNIT_MUL);
      op.mul_op   = mul_op_e'($urandom_range(3, 0));
      op.rs1_data = pick_word();
      op.rs2_data = pick_word();
      send(op);
      @(posedge CLK);
      issue        <= '0;
      stall_commit <= 1'b1;
      @(negedge CLK);
      snap = commit;
      for (int i = 0; i < n; i++) begin
        @(posedge CLK);
        if (i == n - 1)
          stall_commit <= 1'b0;
        @(negedge CLK);
        check("stall_during_mul frozen", 32'd1, word_t'(commit == snap));
      end
      wait_lane(LANE_MU, n + 2, edges);
      check("stall_during_mul latency", word_t'(n + 5), word_t'(edges));
      check("stall_during_mul wdata", mul_model(op.mul_op, op.rs1_data, op.rs2_data),
            commit.mu_wdata);
    end
  endtask

  task automatic flush_in_flight();
    issue_t op;
    int     edges;
    for (int k = 0; k < 2; k++) begin
      op          = base_op(UNIT_MUL);
      op.mul_op   = mul_op_e'(k);
      op.rs1_data = pick_word();
      op.rs2_data = pick_word();
      send(op);
    end
    idle();
    idle();
    // flush lands as the first product reaches the commit latch
    @(posedge CLK);
    flush <= 1'b1;
    @(negedge CLK);
    check("flush_in_flight busy before", 32'd1, word_t'(busy_mu));
    @(posedge CLK);
    flush <= 1'b0;
    @(negedge CLK);
    check("flush_in_flight busy", 32'd0, word_t'(busy_mu));
    for (int i = 0; i < 8; i++) begin
      check("flush_in_flight mu_valid", 32'd0, word_t'(commit.mu_valid));
      @(negedge CLK);
    end
    // pipe must still work after the flush
    op          = base_op(UNIT_MUL);
    op.mul_op   = MUL_MULHSU;
    op.rs1_data = pick_word();
    op.rs2_data = pick_word();
    send(op);
    idle();
    wait_lane(LANE_MU, 1, edges);
    check("flush_in_flight latency", 32'd5, word_t'(edges));
    check("flush_in_flight wdata", mul_model(op.mul_op, op.rs1_data, op.rs2_data),
          commit.mu_wdata);
  endtask

  initial begin
    void'($urandom(14678));
    nRST         <= 1'b0;
    issue        <= '0;
    stall_commit <= 1'b0;
    flush        <= 1'b0;
    repeat (3) @(posedge CLK);
    @(negedge CLK);
    check("reset state", 32'd0, word_t'({commit.au_valid, commit.mu_valid,
          commit.br.valid, busy_mu, mispredict_ff}));
    @(posedge CLK);
    nRST <= 1'b1;
    alu_ops();
    mul_bursts();
    branch_ops();
    stall_during_mul();
    flush_in_flight();
    $display("All tests passed!");
    $finish;
  end

endmodule

/* common/ex_pkg.sv */
// ############################
// shared types of the execute stage
// all widths come from ex_settings.svh
// ############################
`include "ex_settings.svh"

package ex_pkg;

  typedef logic [`EX_XLEN-1:0]   word_t;
  typedef logic [2*`EX_XLEN-1:0] dword_t;
  typedef logic [`EX_REG_W-1:0]  reg_idx_t;
  typedef logic [`EX_TAG_W-1:0]  cb_tag_t;

  typedef enum logic [2:0] {
    UNIT_NONE, UNIT_ALU, UNIT_MUL, UNIT_BRANCH, UNIT_JUMP
  } unit_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
    ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU
  } alu_op_e;

  typedef enum logic [2:0] {
    BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU, BR_JAL, BR_JALR
  } br_op_e;

  typedef enum logic [1:0] {
    MUL_MUL, MUL_MULH, MUL_MULHSU, MUL_MULHU
  } mul_op_e;

  // one operation from decode
  typedef struct packed {
    logic     valid;
    unit_e    unit;
    alu_op_e  alu_op;
    br_op_e   br_op;
    mul_op_e  mul_op;
    word_t    rs1_data;
    word_t    rs2_data;
    word_t    pc;
    word_t    imm;
    logic     prediction;
    reg_idx_t rd;
    cb_tag_t  tag;
  } issue_t;

  // record between multiply stages
  typedef struct packed {
    logic     valid;
    dword_t   accum;
    dword_t   mcand;
    word_t    mplier;
    logic     negate;
    logic     high;
    reg_idx_t rd;
    cb_tag_t  tag;
  } mul_step_t;

  typedef struct packed {
    alu_op_e  op;
    word_t    a;
    word_t    b;
    word_t    pc;
    logic     link;
    reg_idx_t rd;
    cb_tag_t  tag;
    logic     valid;
  } alu_req_t;

  typedef struct packed {
    logic    valid;
    logic    taken;
    logic    prediction;
    word_t   resolved_addr;
    cb_tag_t tag;
  } br_res_t;

  typedef struct packed {
    logic     au_valid;
    reg_idx_t au_rd;
    cb_tag_t  au_tag;
    word_t    au_wdata;
    logic     mu_valid;
    reg_idx_t mu_rd;
    cb_tag_t  mu_tag;
    word_t    mu_wdata;
    br_res_t  br;
  } commit_t;

endpackage

/* common/ex_settings.svh */
// ############################
// widths for the execute stage
// EX_MUL_STAGES must divide EX_XLEN
// ############################
`ifndef EX_SETTINGS_SVH
`define EX_SETTINGS_SVH

// data word
`define EX_XLEN       32
// destination register index
`define EX_REG_W      5
// commit buffer index
`define EX_TAG_W      4
// pipelined multiplier depth
`define EX_MUL_STAGES 4

`endif

/* filelist.f */
+incdir+common
common/ex_pkg.sv
hw/exec_dispatch.sv
hw/alu_unit.sv
hw/branch_resolve.sv
mul/mul_stage.sv
hw/commit_latch.sv
hw/execute_stage.sv
bench/execute_assert.sv
bench/execute_tb.sv

/* hw/alu_unit.sv */
// ############################
// combinational integer ALU
// shifts use the low bits of b only
// ############################
`timescale 1ns/1ns
`include "ex_settings.svh"

module alu_unit
  import ex_pkg::*;
(
  input  alu_req_t alu_req,
  output word_t    au_wdata
);

  localparam int SHAMT_W = $clog2(`EX_XLEN);

  logic [SHAMT_W-1:0] shamt;
  word_t              result;

  assign shamt = alu_req.b[SHAMT_W-1:0];

  always_comb begin
    case (alu_req.op)
      ALU_ADD:  result = alu_req.a + alu_req.b;
      ALU_SUB:  result = alu_req.a - alu_req.b;
      ALU_AND:  result = alu_req.a & alu_req.b;
      ALU_OR:   result = alu_req.a | alu_req.b;
      ALU_XOR:  result = alu_req.a ^ alu_req.b;
      ALU_SLL:  result = alu_req.a << shamt;
      ALU_SRL:  result = alu_req.a >> shamt;
      ALU_SRA:  result = word_t'($signed(alu_req.a) >>> shamt);
      ALU_SLT:  result = word_t'($signed(alu_req.a) < $signed(alu_req.b));
      ALU_SLTU: result = word_t'(alu_req.a < alu_req.b);
      default:  result = '0;
    endcase
  end

  // jal and jalr write the return address
  assign au_wdata = alu_req.link ? alu_req.pc + word_t'(4) : result;

endmodule

/* hw/branch_resolve.sv */
// ############################
// branch compare and redirect
// br lane carries conditional branches only
// ############################
`timescale 1ns/1ns

module branch_resolve
  import ex_pkg::*;
(
  input  logic    CLK,
  input  logic    nRST,
  input  issue_t  issue,
  output br_res_t br_res,
  output logic    mispredict,
  output word_t   brj_addr,
  output logic    mispredict_ff
);

  logic  is_branch;
  logic  is_jump;
  logic  taken;
  word_t pc_imm;
  word_t pc4;
  word_t resolved_addr;
  word_t jump_target;

  assign is_branch = issue.valid & (issue.unit == UNIT_BRANCH);
  assign is_jump   = issue.valid & (issue.unit == UNIT_JUMP);

  always_comb begin
    taken = 1'b0;
    case (issue.br_op)
      BR_BEQ:  taken = issue.rs1_data == issue.rs2_data;
      BR_BNE:  taken = issue.rs1_data != issue.rs2_data;
      BR_BLT:  taken = $signed(issue.rs1_data) < $signed(issue.rs2_data);
      BR_BGE:  taken = $signed(issue.rs1_data) >= $signed(issue.rs2_data);
      BR_BLTU: taken = issue.rs1_data < issue.rs2_data;
      BR_BGEU: taken = issue.rs1_data >= issue.rs2_data;
      BR_JAL:  taken = 1'b1;
      BR_JALR: taken = 1'b1;
    endcase
  end

  assign pc_imm        = issue.pc + issue.imm;
  assign pc4           = issue.pc + word_t'(4);
  assign resolved_addr = taken ? pc_imm : pc4;
  // jalr drops bit 0 of the sum
  assign jump_target   = (issue.br_op == BR_JALR) ?
                         ((issue.rs1_data + issue.imm) & ~word_t'(1)) : pc_imm;

  assign mispredict = is_jump | (is_branch & (taken ^ issue.prediction));
  assign brj_addr   = is_jump ? jump_target : resolved_addr;

  always_comb begin
    br_res.valid         = is_branch;
    br_res.taken         = taken;
    br_res.prediction    = issue.prediction;
    br_res.resolved_addr = resolved_addr;
    br_res.tag           = issue.tag;
  end

  // not held by stall or flush
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      mispredict_ff <= 1'b0;
    end else begin
      mispredict_ff <= mispredict;
    end
  end

endmodule

/* hw/commit_latch.sv */
// ############################
// execute to commit register
// flush wins over hold
// ############################
`timescale 1ns/1ns
`include "ex_settings.svh"

module commit_latch
  import ex_pkg::*;
(
  input  logic      CLK,
  input  logic      nRST,
  input  logic      hold,
  input  logic      flush,
  input  alu_req_t  alu_req,
  input  word_t     au_wdata,
  input  br_res_t   br_res,
  input  mul_step_t mul_done,
  output commit_t   commit
);

  dword_t product;
  word_t  mu_wdata;

  // restore the sign, then pick a half
  always_comb begin
    product  = mul_done.negate ? -mul_done.accum : mul_done.accum;
    mu_wdata = mul_done.high ? product[2*`EX_XLEN-1:`EX_XLEN] : product[`EX_XLEN-1:0];
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      commit <= '0;
    end else if (flush) begin
      commit <= '0;
    end else if (!hold) begin
      // arithmetic lane
      commit.au_valid <= alu_req.valid;
      commit.au_rd    <= alu_req.rd;
      commit.au_tag   <= alu_req.tag;
      commit.au_wdata <= au_wdata;
      // multiply lane
      commit.mu_valid <= mul_done.valid;
      commit.mu_rd    <= mul_done.rd;
      commit.mu_tag   <= mul_done.tag;
      commit.mu_wdata <= mu_wdata;
      // predictor update
      commit.br       <= br_res;
    end
  end

endmodule

/* hw/exec_dispatch.sv */
// ############################
// routes one issued op per cycle
// decode puts the immediate of I-type ops on rs2_data
// ############################
`timescale 1ns/1ns
`include "ex_settings.svh"

module exec_dispatch
  import ex_pkg::*;
(
  input  issue_t    issue,
  input  logic      stall_commit,
  output alu_req_t  alu_req,
  output mul_step_t mul_req
);

  logic  issued;
  logic  a_signed;
  logic  b_signed;
  logic  a_neg;
  logic  b_neg;
  word_t a_mag;
  word_t b_mag;

  assign issued = issue.valid & ~stall_commit;

  // jumps ride the alu lane as link writes
  always_comb begin
    alu_req.valid = issued & ((issue.unit == UNIT_ALU) | (issue.unit == UNIT_JUMP));
    alu_req.op    = issue.alu_op;
    alu_req.a     = issue.rs1_data;
    alu_req.b     = issue.rs2_data;
    alu_req.pc    = issue.pc;
    alu_req.link  = issue.unit == UNIT_JUMP;
    alu_req.rd    = issue.rd;
    alu_req.tag   = issue.tag;
  end

  // signedness of each operand
  assign a_signed = (issue.mul_op == MUL_MULH) | (issue.mul_op == MUL_MULHSU);
  assign b_signed = issue.mul_op == MUL_MULH;
  assign a_neg    = a_signed & issue.rs1_data[`EX_XLEN-1];
  assign b_neg    = b_signed & issue.rs2_data[`EX_XLEN-1];
  assign a_mag    = a_neg ? -issue.rs1_data : issue.rs1_data;
  assign b_mag    = b_neg ? -issue.rs2_data : issue.rs2_data;

  // unsigned magnitudes go down the pipe and the sign is restored at commit
  always_comb begin
    mul_req.valid  = issued & (issue.unit == UNIT_MUL);
    mul_req.accum  = '0;
    mul_req.mcand  = {{`EX_XLEN{1'b0}}, a_mag};
    mul_req.mplier = b_mag;
    mul_req.negate = a_neg ^ b_neg;
    mul_req.high   = issue.mul_op != MUL_MUL;
    mul_req.rd     = issue.rd;
    mul_req.tag    = issue.tag;
  end

endmodule

/* hw/execute_stage.sv */
// ############################
// integer execute stage top
// no issue allowed while stall_commit is high
// ############################
`timescale 1ns/1ns
`include "ex_settings.svh"

module execute_stage
  import ex_pkg::*;
(
  input  logic    CLK,
  input  logic    nRST,
  input  issue_t  issue,
  input  logic    stall_commit,
  input  logic    flush,
  output commit_t commit,
  output logic    mispredict,
  output word_t   brj_addr,
  output logic    mispredict_ff,
  output logic    busy_mu
);

  alu_req_t                  alu_req;
  word_t                     au_wdata;
  br_res_t                   br_res;
  mul_step_t                 mul_chain [`EX_MUL_STAGES+1];
  logic [`EX_MUL_STAGES-1:0] stage_valid;

  exec_dispatch u_dispatch (
    .issue        (issue),
    .stall_commit (stall_commit),
    .alu_req      (alu_req),
    .mul_req      (mul_chain[0])
  );

  alu_unit u_alu (
    .alu_req  (alu_req),
    .au_wdata (au_wdata)
  );

  branch_resolve u_branch (
    .CLK           (CLK),
    .nRST          (nRST),
    .issue         (issue),
    .br_res        (br_res),
    .mispredict    (mispredict),
    .brj_addr      (brj_addr),
    .mispredict_ff (mispredict_ff)
  );

  // stage gi feeds stage gi+1
  for (genvar gi = 0; gi < `EX_MUL_STAGES; gi++) begin : g_mul
    mul_stage u_mul_stage (
      .CLK      (CLK),
      .nRST     (nRST),
      .hold     (stall_commit),
      .flush    (flush),
      .step_in  (mul_chain[gi]),
      .step_out (mul_chain[gi+1])
    );
    assign stage_valid[gi] = mul_chain[gi+1].valid;
  end

  assign busy_mu = |stage_valid;

  commit_latch u_commit (
    .CLK      (CLK),
    .nRST     (nRST),
    .hold     (stall_commit),
    .flush    (flush),
    .alu_req  (alu_req),
    .au_wdata (au_wdata),
    .br_res   (br_res),
    .mul_done (mul_chain[`EX_MUL_STAGES]),
    .commit   (commit)
  );

endmodule

/* mul/mul_stage.sv */
// ############################
// one step of the multiplier
// consumes EX_XLEN/EX_MUL_STAGES bits
// ############################
`timescale 1ns/1ns
`include "ex_settings.svh"

module mul_stage
  import ex_pkg::*;
(
  input  logic      CLK,
  input  logic      nRST,
  input  logic      hold,
  input  logic      flush,
  input  mul_step_t step_in,
  output mul_step_t step_out
);

  localparam int STEP_W = `EX_XLEN / `EX_MUL_STAGES;

  dword_t    digit;
  mul_step_t step_next;
  mul_step_t step_q;
  logic      valid_q;

  // partial product of the low digit
  always_comb begin
    digit              = '0;
    digit[STEP_W-1:0]  = step_in.mplier[STEP_W-1:0];
    step_next          = step_in;
    step_next.accum    = step_in.accum + step_in.mcand * digit;
    step_next.mcand    = step_in.mcand << STEP_W;
    step_next.mplier   = step_in.mplier >> STEP_W;
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      valid_q <= 1'b0;
    end else if (flush) begin
      valid_q <= 1'b0;
    end else if (!hold) begin
      valid_q <= step_in.valid;
    end
  end

  always_ff @(posedge CLK) begin
    if (!hold) begin
      step_q <= step_next;
    end
  end

  always_comb begin
    step_out       = step_q;
    step_out.valid = valid_q;
  end

endmodule

/* run.sh */
#!/bin/sh
# build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
  --top-module execute_tb -Mdir obj_dir -f filelist.f
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/Vexecute_tb > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "Test failures found" sim.log; then
  echo "FAIL"
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "FAIL: simulator exited with status $run_status"
  exit 1
fi
echo "PASS"
exit 0
